// File: hw/lasram_consts.svh
/*
 * lasram memory map and access timing
 * address windows are picked by the top byte of the bus address,
 * SRAM access lengths are counted in clocks from the request pulse
 */

`ifndef LASRAM_CONSTS_SVH
`define LASRAM_CONSTS_SVH

// ------------------------------------------------------------------------
// address windows
// ------------------------------------------------------------------------
// external SRAM window
`define SRAM_BASE 8'h00
// on-chip scratch window
`define SCRATCH_BASE 8'h01

// scratch depth in 32-bit words
`define SCRATCH_WORDS 256

// ------------------------------------------------------------------------
// SRAM access lengths, in clocks
// ------------------------------------------------------------------------
`define SRAM_WRITE_LEN 4
`define SRAM_READ_LEN 5

`endif

// File: hw/lasram_pkg.sv
/*
 * lasram shared types
 * look-ahead request and packed return of the core bus,
 * SRAM pin types and the SRAM controller states
 */

package lasram_pkg;

    // ------------------------------------------------------------------------
    // plain vectors
    // ------------------------------------------------------------------------
    // bus address, top byte selects the window
    typedef logic [31:0] addr_t;
    // data word on the core bus
    typedef logic [31:0] word_t;
    // one byte on the SRAM data pins
    typedef logic [7:0] byte_t;
    // one strobe per byte lane
    typedef logic [3:0] wstrb_t;
    // SRAM address pins
    typedef logic [23:0] sram_addr_t;
    // byte-cycle counter, long enough for the read length
    typedef logic [2:0] cyc_t;

    // ------------------------------------------------------------------------
    // bus structs
    // ------------------------------------------------------------------------
    // look-ahead request, read and write are single-clock pulses
    // addr, wdata and wstrb stay put until ready comes back
    typedef struct packed {
        logic   read;
        logic   write;
        addr_t  addr;
        word_t  wdata;
        wstrb_t wstrb;
    } mem_la_req_t;

    // packed return, all zero outside the ready pulse
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mem_ret_t;

    // SRAM byte controller states
    // access steps through the bytes, done is the extra read clock
    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_done
    } sram_state_t;

endpackage

// File: hw/sram_byte_ctrl.sv
/*
 * async SRAM byte controller
 * serves one 32-bit look-ahead access over an 8-bit SRAM bus,
 * one byte per clock, little-endian across consecutive addresses
 * write is ready 4 clocks after the pulse, read 5 clocks after
 */

`include "lasram_consts.svh"

module sram_byte_ctrl #(
    parameter logic [7:0] base_addr = `SRAM_BASE
) (
    input  logic                      clk,
    input  logic                      rst,
    input  lasram_pkg::mem_la_req_t   req,
    output lasram_pkg::mem_ret_t      ret,
    output lasram_pkg::sram_addr_t    ram_address,
    inout  wire lasram_pkg::byte_t    ram_data,
    output logic                      ram_nce,
    output logic                      ram_noe,
    output logic                      ram_nwe
);
    import lasram_pkg::*;

    // index of the last byte lane in a word
    localparam cyc_t last_byte = cyc_t'($bits(word_t) / 8 - 1);
    // counter value at the clock that completes each access kind
    localparam cyc_t write_end = cyc_t'(`SRAM_WRITE_LEN - 1);
    localparam cyc_t read_end = cyc_t'(`SRAM_READ_LEN - 1);

    sram_state_t state;
    // byte lane currently on the pins, keeps counting in done
    cyc_t        cnt;
    logic        is_write;
    // read bytes gathered here, lane i lands in bits 8i+7..8i
    word_t       acc;
    byte_t       wr_byte;

    logic        sel;
    logic        present;
    cyc_t        pidx;
    logic        pwr;

    // chip and outputs always enabled, nwe alone steers the bus
    assign ram_nce = 1'b0;
    assign ram_noe = 1'b0;

    // drive the pins only while a write strobe is low
    assign ram_data = ram_nwe ? 'z : wr_byte;

    // pick which byte goes on the pins next clock
    always_comb begin
        sel = (req.addr[31:24] == base_addr) && (req.read || req.write);
        present = 1'b0;
        pidx = cnt + 1'b1;
        pwr = is_write;
        case (state)
            st_idle: begin
                // the pulse itself puts byte 0 out
                if (sel) begin
                    present = 1'b1;
                    pidx = '0;
                    pwr = req.write;
                end
            end
            st_access: begin
                present = (cnt < last_byte);
            end
            default: begin
                present = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // access FSM, strobes and read assembly
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt <= '0;
            is_write <= 1'b0;
            acc <= '0;
            ret <= '0;
            ram_nwe <= 1'b1;
        end else begin
            ret <= '0;
            ram_nwe <= 1'b1;
            // low for one clock per strobed byte
            if (present) begin
                ram_nwe <= !(pwr && req.wstrb[pidx[1:0]]);
            end
            case (state)
                st_idle: begin
                    if (sel) begin
                        state <= st_access;
                        cnt <= '0;
                        is_write <= req.write;
                    end
                end
                st_access: begin
                    cnt <= cnt + 1'b1;
                    // byte from the previous clock's address
                    if (!is_write) begin
                        acc[8 * cnt[1:0] +: 8] <= ram_data;
                    end
                    if (is_write && cnt == write_end) begin
                        ret.ready <= 1'b1;
                        state <= st_idle;
                    end else if (cnt == last_byte) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == read_end) begin
                        ret.ready <= 1'b1;
                        ret.rdata <= acc;
                        acc <= '0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address and write byte for the lane being presented
    always_ff @(posedge clk) begin
        if (present) begin
            ram_address <= req.addr[23:0] + sram_addr_t'(pidx);
            wr_byte <= req.wdata[8 * pidx[1:0] +: 8];
        end
    end

endmodule

// File: hw/scratch_ram.sv
/*
 * on-chip scratch RAM
 * word array with byte strobes in its own address window,
 * answers reads and writes one clock after the request pulse
 */

`include "lasram_consts.svh"

module scratch_ram #(
    parameter logic [7:0] base_addr = `SCRATCH_BASE,
    parameter int         words     = `SCRATCH_WORDS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  lasram_pkg::mem_la_req_t req,
    output lasram_pkg::mem_ret_t    ret
);
    import lasram_pkg::*;

    localparam int idx_w = $clog2(words);

    word_t            mem [words];
    logic             sel;
    // word index with the byte offset bits dropped
    logic [idx_w-1:0] idx;
    // set by the pulse and answered on the next clock
    logic             pend;
    // read word for the ready clock and zero between reads
    word_t            rd_word;

    always_comb begin
        sel = (req.addr[31:24] == base_addr) && (req.read || req.write);
        idx = req.addr[2 +: idx_w];
    end

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    // only strobed lanes change
    always_ff @(posedge clk) begin
        if (sel && req.write) begin
            for (int b = 0; b < $bits(wstrb_t); b++) begin
                if (req.wstrb[b]) begin
                    mem[idx][8 * b +: 8] <= req.wdata[8 * b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // return
    // ------------------------------------------------------------------------
    // request kind latched on the pulse and ready one clock later
    // rdata stays zero for writes and between accesses
    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
            rd_word <= '0;
            ret <= '0;
        end else begin
            pend <= sel;
            rd_word <= (sel && req.read) ? mem[idx] : '0;
            ret.ready <= pend;
            ret.rdata <= rd_word;
        end
    end

endmodule

// File: hw/mem_bus_fabric.sv
/*
 * return merge and unmapped responder
 * answers any access outside the mapped windows with zero data
 * one clock later, then ORs every slave return onto the core bus
 */

`include "lasram_consts.svh"

module mem_bus_fabric #(
    parameter logic [7:0] sram_base    = `SRAM_BASE,
    parameter logic [7:0] scratch_base = `SCRATCH_BASE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  lasram_pkg::mem_la_req_t req,
    input  lasram_pkg::mem_ret_t    sram_ret,
    input  lasram_pkg::mem_ret_t    scratch_ret,
    output lasram_pkg::mem_ret_t    ret
);
    import lasram_pkg::*;

    logic [7:0] base;
    logic       pulse;
    logic       unmapped;
    logic       unm_pend;
    logic       unm_ready;
    mem_ret_t   unm_ret;

    // ------------------------------------------------------------------------
    // unmapped decode
    // ------------------------------------------------------------------------
    assign base = req.addr[31:24];
    assign pulse = req.read || req.write;

    // no window claims this base
    assign unmapped = pulse && (base != sram_base) && (base != scratch_base);

    // stray writes go nowhere and only the ready comes back
    // flagged on the pulse and answered on the clock after
    always_ff @(posedge clk) begin
        if (rst) begin
            unm_pend <= 1'b0;
            unm_ready <= 1'b0;
        end else begin
            unm_pend <= unmapped;
            unm_ready <= unm_pend;
        end
    end

    assign unm_ret = '{ready: unm_ready, rdata: '0};

    // ------------------------------------------------------------------------
    // return merge
    // ------------------------------------------------------------------------
    // slaves hold their returns at zero outside the ready pulse
    // and only one access is ever in flight, so a plain OR is enough
    assign ret = mem_ret_t'(sram_ret | scratch_ret | unm_ret);

endmodule

// File: hw/lasram_top.sv
/*
 * lasram memory subsystem top
 * look-ahead request fans out to the SRAM controller, the scratch RAM
 * and the fabric, the fabric merges the returns onto the core bus
 */

`include "lasram_consts.svh"

module lasram_top (
    input  logic                      clk,
    input  logic                      rst,
    input  lasram_pkg::mem_la_req_t   req,
    output lasram_pkg::mem_ret_t      ret,
    // external async SRAM
    output lasram_pkg::sram_addr_t    ram_address,
    inout  wire lasram_pkg::byte_t    ram_data,
    output logic                      ram_nce,
    output logic                      ram_noe,
    output logic                      ram_nwe
);
    import lasram_pkg::*;

    mem_ret_t sram_ret;
    mem_ret_t scratch_ret;

    // ------------------------------------------------------------------------
    // slaves
    // ------------------------------------------------------------------------
    sram_byte_ctrl #(
        .base_addr   (`SRAM_BASE)
    ) u_sram (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .ret         (sram_ret),
        .ram_address (ram_address),
        .ram_data    (ram_data),
        .ram_nce     (ram_nce),
        .ram_noe     (ram_noe),
        .ram_nwe     (ram_nwe)
    );

    scratch_ram #(
        .base_addr (`SCRATCH_BASE),
        .words     (`SCRATCH_WORDS)
    ) u_scratch (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ret       (scratch_ret)
    );

    // unmapped responder and return merge
    mem_bus_fabric #(
        .sram_base    (`SRAM_BASE),
        .scratch_base (`SCRATCH_BASE)
    ) u_fabric (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .sram_ret     (sram_ret),
        .scratch_ret  (scratch_ret),
        .ret          (ret)
    );

endmodule

// File: sim/sram_chip_model.sv
/*
 * behavioral 512K x 8 asynchronous SRAM
 * drives the stored byte while the write strobe is high,
 * stores the bus byte while it is low
 */

module sram_chip_model (
    input  logic        clk,
    input  logic [18:0] addr,
    inout  wire  [7:0]  data,
    input  logic        nce,
    input  logic        noe,
    input  logic        nwe
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] mem [0:524287];

    // read path, combinational from the address pins
    assign data = (!nce && !noe && nwe) ? mem[addr] : 8'bz;

    // write strobe sampled mid-cycle, where address and data have settled
    // back-to-back strobed bytes keep nwe low, so no edge of nwe is used
    always @(negedge clk) begin
        if (!nce && !nwe) begin
            mem[addr] <= data;
        end
    end

endmodule

// File: sim/lasram_tb.sv
/*
 * lasram testbench
 * drives look-ahead accesses into the memory subsystem, predicts each
 * return from shadow copies of the SRAM and scratch contents, and
 * checks data, ready latency and the SRAM write strobe
 */

`include "lasram_consts.svh"

module lasram_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lasram_pkg::*;

    // longest wait for a ready pulse in clocks
    localparam int ready_timeout = 20;
    // SRAM bytes under test are all preloaded before any read
    localparam int sram_span = 128;

    logic        clk = 1'b0;
    logic        rst;
    mem_la_req_t req;
    mem_ret_t    ret;
    sram_addr_t  ram_address;
    wire byte_t  ram_data;
    logic        ram_nce;
    logic        ram_noe;
    logic        ram_nwe;

    logic [31:0] seed = 32'h2c3a_08fd;
    byte_t       sram_shadow [sram_span];
    word_t       scratch_shadow [`SCRATCH_WORDS];

    // open access handed from the driver to the checker
    int          issue_id = 0;
    int          done_id = 0;
    logic        exp_read = 1'b0;
    word_t       exp_data = '0;
    int          exp_lat = 0;
    // edge 0 samples the pulse, so the count starts one below zero
    int          elapsed = -1;
    int          checks = 0;
    int          errors = 0;
    int          test_errors;
    int          test_accesses;
    // set once an access never got its ready
    logic        hung = 1'b0;

    always #50 clk = ~clk;

    lasram_top dut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .ret         (ret),
        .ram_address (ram_address),
        .ram_data    (ram_data),
        .ram_nce     (ram_nce),
        .ram_noe     (ram_noe),
        .ram_nwe     (ram_nwe)
    );

    sram_chip_model sram_chip (
        .clk  (clk),
        .addr (ram_address[18:0]),
        .data (ram_data),
        .nce  (ram_nce),
        .noe  (ram_noe),
        .nwe  (ram_nwe)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // writes update the strobed bytes, reads return the predicted word
    // unmapped reads and every write return zero
    function automatic word_t ref_access(input logic rd, input addr_t a, input word_t wd,
                                         input wstrb_t ws);
        word_t      w;
        logic [6:0] p;
        w = '0;
        if (a[31:24] == `SRAM_BASE) begin
            for (int i = 0; i < 4; i++) begin
                // lane i lives at the i-th SRAM address up
                p = a[6:0] + 7'(i);
                if (rd) begin
                    w[8 * i +: 8] = sram_shadow[p];
                end else if (ws[i]) begin
                    sram_shadow[p] = wd[8 * i +: 8];
                end
            end
        end else if (a[31:24] == `SCRATCH_BASE) begin
            for (int i = 0; i < 4; i++) begin
                if (rd) begin
                    w[8 * i +: 8] = scratch_shadow[a[9:2]][8 * i +: 8];
                end else if (ws[i]) begin
                    scratch_shadow[a[9:2]][8 * i +: 8] = wd[8 * i +: 8];
                end
            end
        end
        return w;
    endfunction

    // one access pulses the request, holds the operands and waits for the checker
    task automatic bus_access(input logic rd, input addr_t a, input word_t wd, input wstrb_t ws);
        int waited;
        if (hung) begin
            return;
        end
        @(negedge clk);
        req.read = rd;
        req.write = !rd;
        req.addr = a;
        req.wdata = wd;
        req.wstrb = ws;
        exp_read = rd;
        exp_data = ref_access(rd, a, wd, ws);
        // scratch and unmapped answer on the next clock
        exp_lat = 1;
        if (a[31:24] == `SRAM_BASE) begin
            exp_lat = rd ? `SRAM_READ_LEN : `SRAM_WRITE_LEN;
        end
        issue_id++;
        test_accesses++;
        @(negedge clk);
        req.read = 1'b0;
        req.write = 1'b0;
        waited = 0;
        while (issue_id != done_id && waited < ready_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (issue_id != done_id) begin
            errors++;
            hung = 1'b1;
            $display("timeout: no ready within %0d clocks for address %h", ready_timeout, a);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d accesses, %0d errors", num, name, test_accesses,
                 errors - test_errors);
        test_accesses = 0;
        test_errors = errors;
    endtask

    // ------------------------------------------------------------------------
    // checker samples the registered outputs at the rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            // write strobe stays high when idle and during reads
            if (issue_id == done_id || exp_read) begin
                checks++;
                assert (ram_nwe === 1'b1)
                else begin
                    errors++;
                    $display("[FAIL] t=%0d ns: ram_nwe low outside a write", $time);
                end
            end
            if (issue_id != done_id) begin
                if (ret.ready === 1'b1) begin
                    checks += 2;
                    assert (ret.rdata === exp_data)
                    else begin
                        errors++;
                        $display("[FAIL] t=%0d ns: rdata %h, expected %h", $time,
                                 ret.rdata, exp_data);
                    end
                    assert (elapsed == exp_lat)
                    else begin
                        errors++;
                        $display("[FAIL] t=%0d ns: ready after %0d clocks, expected %0d",
                                 $time, elapsed, exp_lat);
                    end
                    done_id++;
                    elapsed = -1;
                end else begin
                    elapsed++;
                end
            end else begin
                checks++;
                assert (ret.ready === 1'b0)
                else begin
                    errors++;
                    $display("[FAIL] t=%0d ns: ready with no access open", $time);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        addr_t       a;
        rst = 1'b1;
        req = '0;
        test_accesses = 0;
        test_errors = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // every byte a later read can reach gets a known value
        for (int i = 0; i < sram_span; i += 4) begin
            bus_access(1'b0, {`SRAM_BASE, 24'(i)}, next_rand(), 4'hf);
        end
        for (int i = 0; i < `SCRATCH_WORDS; i++) begin
            bus_access(1'b0, {`SCRATCH_BASE, 14'h0, 8'(i), 2'b00}, next_rand(), 4'hf);
        end
        report_test(0, "preload");

        bus_access(1'b0, {`SRAM_BASE, 24'd8}, 32'h4433_2211, 4'hf);
        bus_access(1'b1, {`SRAM_BASE, 24'd8}, '0, 4'h0);
        // unaligned reads show which address each byte landed on
        bus_access(1'b1, {`SRAM_BASE, 24'd9}, '0, 4'h0);
        bus_access(1'b1, {`SRAM_BASE, 24'd11}, '0, 4'h0);
        report_test(1, "sram word write and read");

        for (int s = 0; s < 16; s++) begin
            bus_access(1'b0, {`SRAM_BASE, 24'd16}, next_rand(), 4'(s));
            bus_access(1'b1, {`SRAM_BASE, 24'd16}, '0, 4'h0);
        end
        report_test(2, "sram partial strobes");

        for (int i = 0; i < 4; i++) begin
            bus_access(1'b0, {`SRAM_BASE, 24'(40 + 4 * i)}, next_rand(), 4'hf);
            bus_access(1'b1, {`SRAM_BASE, 24'(40 + 4 * i)}, '0, 4'h0);
        end
        report_test(3, "sram latency and strobe");

        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            bus_access(r[31], {`SCRATCH_BASE, 14'h0, r[23:16], 2'b00}, next_rand(), r[27:24]);
        end
        report_test(4, "scratch random");

        bus_access(1'b1, 32'h0200_0008, '0, 4'h0);
        bus_access(1'b1, 32'hff00_0000, '0, 4'h0);
        bus_access(1'b0, 32'h0200_0008, 32'hdead_beef, 4'hf);
        bus_access(1'b0, 32'h8000_0008, 32'hcafe_f00d, 4'hf);
        // same low address bits in both mapped windows must be untouched
        bus_access(1'b1, {`SRAM_BASE, 24'd8}, '0, 4'h0);
        bus_access(1'b1, {`SCRATCH_BASE, 24'd8}, '0, 4'h0);
        report_test(5, "unmapped");

        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            case (r[31:30])
                2'd1: a = {`SCRATCH_BASE, 14'h0, r[23:16], 2'b00};
                2'd2: a = {1'b1, r[6:0], r[23:0]};
                default: a = {`SRAM_BASE, 24'(r[15:0] % 16'd125)};
            endcase
            bus_access(r[29], a, next_rand(), r[27:24]);
        end
        report_test(6, "random mixed");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: lasram.f
+incdir+hw
hw/lasram_pkg.sv
hw/sram_byte_ctrl.sv
hw/scratch_ram.sv
hw/mem_bus_fabric.sv
hw/lasram_top.sv
sim/sram_chip_model.sv
sim/lasram_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the lasram testbench with Verilator, run it, and search for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module lasram_tb -f lasram.f -o lasram_sim \
    && ./obj_dir/lasram_sim | tee /dev/stderr | grep -q "Simulation passed" \
    && exit 0 || exit 1
